// File: logic/dmem_settings.svh
/* data memory wrapper settings
   memory depth, control register count, address fields and region codes */
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// word address width, 1024 words
`define DMEM_WORD_BITS 10

// scratch control registers
`define CR_COUNT 8

// address fields
`define CORE_ID_MSB 31
`define CORE_ID_LSB 24
`define REGION_MSB 23
`define REGION_LSB 22

// region codes
`define DMEM_REGION 2'd0
`define CR_REGION 2'd3

`endif

// File: logic/dmem_pkg.sv
/* data memory wrapper types
   ring opcodes, decoded core targets and a thread encoder */
package dmem_pkg;

    // ring opcode
    typedef enum logic [1:0] {
        RD    = 2'b00,
        WR    = 2'b01,
        RDRSP = 2'b10
    } tOpcode;

    // where a core access goes
    typedef enum logic [1:0] {
        TGT_NONE   = 2'b00,
        TGT_DMEM   = 2'b01,
        TGT_CR     = 2'b10,
        TGT_REMOTE = 2'b11
    } tTarget;

    // one-hot thread to binary, highest bit wins
    function automatic logic [1:0] oneHotToBin(input logic [3:0] oneHot);
        logic [1:0] bin;
        bin = 2'd0;
        if (oneHot[1]) begin
            bin = 2'd1;
        end
        if (oneHot[2]) begin
            bin = 2'd2;
        end
        if (oneHot[3]) begin
            bin = 2'd3;
        end
        return bin;
    endfunction

endpackage

// File: logic/data_sram.sv
/* dual-port data memory, byte enables on port a,
   full-word writes on port b, registered reads on both */
`timescale 1ns/1ps
`include "dmem_settings.svh"

module data_sram (
    input  logic                       QClk,
    // port a, core
    input  logic [`DMEM_WORD_BITS-1:0] aAddr,
    input  logic [3:0]                 aByteEn,
    input  logic [31:0]                aWrData,
    input  logic                       aRdEn,
    input  logic                       aWrEn,
    output logic [31:0]                aRdData,
    // port b, ring
    input  logic [`DMEM_WORD_BITS-1:0] bAddr,
    input  logic [31:0]                bWrData,
    input  logic                       bRdEn,
    input  logic                       bWrEn,
    output logic [31:0]                bRdData
);

localparam int Depth = 1 << `DMEM_WORD_BITS;

logic [31:0] mem [Depth];

// ====================
// both ports, one process
// ====================
always_ff @(posedge QClk) begin
    // ring write, full word
    if (bWrEn) begin
        mem[bAddr] <= bWrData;
    end
    // core write after it, so core wins on same address
    if (aWrEn) begin
        for (int i = 0; i < 4; i++) begin
            if (aByteEn[i]) begin
                mem[aAddr][8*i +: 8] <= aWrData[8*i +: 8];
            end
        end
    end
    // reads see the old word on a collision
    if (aRdEn) begin
        aRdData <= mem[aAddr];
    end
    if (bRdEn) begin
        bRdData <= mem[bAddr];
    end
end

endmodule

// File: logic/ctrl_regs.sv
/* control register file: scratch bank, core id, thread frozen mask
   and thread id, with a core port and a ring port */
`timescale 1ns/1ps
`include "dmem_settings.svh"

module ctrl_regs
    import dmem_pkg::*;
(
    input  logic                       QClk,
    input  logic                       rstN,
    input  logic [7:0]                 coreId,
    // core port
    input  logic [3:0]                 thread,
    input  logic [`DMEM_WORD_BITS-1:0] coreAddr,
    input  logic [31:0]                coreWrData,
    input  logic                       crRdEn,
    input  logic                       crWrEn,
    output logic [31:0]                crRdData,
    // ring port
    input  logic [`DMEM_WORD_BITS-1:0] ringAddr,
    input  logic [31:0]                ringWrData,
    input  logic                       ringCrRd,
    input  logic                       ringCrWr,
    output logic [31:0]                ringCrData,
    output logic [3:0]                 threadFrozen
);

// word offsets after the scratch bank
localparam int CrIdxBits    = $clog2(`CR_COUNT);
localparam int CoreIdOffset = `CR_COUNT;
localparam int FrozenOffset = `CR_COUNT + 1;
localparam int ThreadOffset = `CR_COUNT + 2;

logic [31:0] scratch [`CR_COUNT];
logic        coreScratchWr;
logic        ringScratchWr;
logic [31:0] coreView;
logic [31:0] ringView;

assign coreScratchWr = crWrEn && (coreAddr < `CR_COUNT);
assign ringScratchWr = ringCrWr && (ringAddr < `CR_COUNT);

// ====================
// read views
// ====================
always_comb begin
    coreView = '0;
    if (coreAddr < `CR_COUNT) begin
        coreView = scratch[coreAddr[CrIdxBits-1:0]];
    end else if (coreAddr == CoreIdOffset) begin
        coreView = {24'd0, coreId};
    end else if (coreAddr == FrozenOffset) begin
        coreView = {28'd0, threadFrozen};
    end else if (coreAddr == ThreadOffset) begin
        // requesting thread number, core side only
        coreView = {30'd0, oneHotToBin(thread)};
    end
end

always_comb begin
    ringView = '0;
    if (ringAddr < `CR_COUNT) begin
        ringView = scratch[ringAddr[CrIdxBits-1:0]];
    end else if (ringAddr == CoreIdOffset) begin
        ringView = {24'd0, coreId};
    end else if (ringAddr == FrozenOffset) begin
        ringView = {28'd0, threadFrozen};
    end
end

// frozen mask, core write first
always_ff @(posedge QClk or negedge rstN) begin
    if (!rstN) begin
        threadFrozen <= '0;
    end else if (crWrEn && (coreAddr == FrozenOffset)) begin
        threadFrozen <= coreWrData[3:0];
    end else if (ringCrWr && (ringAddr == FrozenOffset)) begin
        threadFrozen <= ringWrData[3:0];
    end
end

// scratch writes and registered reads
always_ff @(posedge QClk) begin
    if (ringScratchWr) begin
        scratch[ringAddr[CrIdxBits-1:0]] <= ringWrData;
    end
    // later assignment, core wins
    if (coreScratchWr) begin
        scratch[coreAddr[CrIdxBits-1:0]] <= coreWrData;
    end
    if (crRdEn) begin
        crRdData <= coreView;
    end
    if (ringCrRd) begin
        ringCrData <= ringView;
    end
end

endmodule

// File: logic/access_router.sv
/* access router: decodes core and ring requests, issues remote requests
   and holds one remote load response per thread */
`timescale 1ns/1ps
`include "dmem_settings.svh"

module access_router
    import dmem_pkg::*;
(
    input  logic        QClk,
    input  logic        rstN,
    input  logic [7:0]  coreId,
    // core side, stage 103
    input  logic [3:0]  thread,
    input  logic [31:0] addr,
    input  logic        rdEn,
    input  logic        wrEn,
    input  logic [31:0] wrData,
    // ring inbound
    input  logic        ringReqValid,
    input  tOpcode      ringReqOpcode,
    input  logic [31:0] ringReqAddr,
    // remote response, any time
    input  logic        remoteRspValid,
    input  logic [1:0]  remoteRspThread,
    input  logic [31:0] remoteRspData,
    // local enables
    output logic        dmemRdEn,
    output logic        dmemWrEn,
    output logic        crRdEn,
    output logic        crWrEn,
    output logic        ringDmemRd,
    output logic        ringDmemWr,
    output logic        ringCrRd,
    output logic        ringCrWr,
    output tTarget      target,
    // remote request, same cycle
    output logic        remoteReqValid,
    output tOpcode      remoteReqOpcode,
    output logic [1:0]  remoteReqThread,
    output logic [31:0] remoteReqAddr,
    output logic [31:0] remoteReqData,
    output logic [3:0]  threadWaiting,
    output logic [31:0] heldData,
    output logic        matchNow
);

logic        coreAccess;
logic        isLocal;
logic [1:0]  coreRegion;
logic [1:0]  ringRegion;
logic [1:0]  threadNum;
logic        ringRd;
logic        ringWr;
logic [3:0]  rspReady;
logic [3:0]  loadIssue;
logic [3:0]  consume;
logic [31:0] rspData [4];

// ====================
// core decode
// ====================
assign coreAccess = rdEn | wrEn;
// core id zero is an alias of this core
assign isLocal    = (addr[`CORE_ID_MSB:`CORE_ID_LSB] == 8'd0) ||
                    (addr[`CORE_ID_MSB:`CORE_ID_LSB] == coreId);
assign coreRegion = addr[`REGION_MSB:`REGION_LSB];
assign threadNum  = oneHotToBin(thread);

always_comb begin
    target = TGT_NONE;
    if (coreAccess) begin
        if (!isLocal) begin
            target = TGT_REMOTE;
        end else if (coreRegion == `DMEM_REGION) begin
            target = TGT_DMEM;
        end else if (coreRegion == `CR_REGION) begin
            target = TGT_CR;
        end
    end
end

assign dmemRdEn = rdEn && (target == TGT_DMEM);
assign dmemWrEn = wrEn && (target == TGT_DMEM);
assign crRdEn   = rdEn && (target == TGT_CR);
assign crWrEn   = wrEn && (target == TGT_CR);

// ====================
// ring decode
// ====================
// core id field not checked, the ring already delivered it here
assign ringRegion = ringReqAddr[`REGION_MSB:`REGION_LSB];
assign ringRd     = ringReqValid && (ringReqOpcode == RD);
assign ringWr     = ringReqValid && (ringReqOpcode == WR);
assign ringDmemRd = ringRd && (ringRegion == `DMEM_REGION);
assign ringDmemWr = ringWr && (ringRegion == `DMEM_REGION);
assign ringCrRd   = ringRd && (ringRegion == `CR_REGION);
assign ringCrWr   = ringWr && (ringRegion == `CR_REGION);

// ====================
// remote issue and return
// ====================
// replay of a thread with a held response
assign matchNow        = coreAccess && |(rspReady & thread);
// a replay consumes the held data, no new request
assign remoteReqValid  = (target == TGT_REMOTE) && !matchNow;
assign remoteReqOpcode = wrEn ? WR : RD;
assign remoteReqThread = threadNum;
assign remoteReqAddr   = addr;
assign remoteReqData   = wrData;

assign loadIssue = (remoteReqValid && rdEn) ? thread : 4'b0000;
assign consume   = matchNow ? thread : 4'b0000;

always_ff @(posedge QClk or negedge rstN) begin
    if (!rstN) begin
        threadWaiting <= '0;
        rspReady      <= '0;
    end else begin
        threadWaiting <= (threadWaiting & ~consume) | loadIssue;
        for (int i = 0; i < 4; i++) begin
            // new response beats a replay in the same cycle
            if (remoteRspValid && (remoteRspThread == 2'(i))) begin
                rspReady[i] <= 1'b1;
            end else if (consume[i]) begin
                rspReady[i] <= 1'b0;
            end
        end
    end
end

// response data per thread
always_ff @(posedge QClk) begin
    if (remoteRspValid) begin
        rspData[remoteRspThread] <= remoteRspData;
    end
end

assign heldData = rspData[threadNum];

endmodule

// File: logic/read_return.sv
/* read return stage: picks the core read data in stage 104
   and forms the ring read response */
`timescale 1ns/1ps

module read_return
    import dmem_pkg::*;
(
    input  logic        QClk,
    input  logic        rstN,
    // stage 103 selects
    input  tTarget      target,
    input  logic        rdEn,
    input  logic        matchNow,
    input  logic [31:0] heldData,
    // stage 104 core results
    input  logic [31:0] dmemRdData,
    input  logic [31:0] crRdData,
    // ring read kinds and results
    input  logic        ringDmemRd,
    input  logic        ringCrRd,
    input  logic [31:0] dmemRingData,
    input  logic [31:0] crRingData,
    output logic [31:0] coreRdData,
    output logic        remoteMatch,
    output logic        ringRspValid,
    output logic [31:0] ringRspData
);

tTarget      targetQ104;
logic        rdEnQ104;
logic [31:0] heldQ104;
logic        ringDmemRdQ104;
logic        ringCrRdQ104;

always_ff @(posedge QClk or negedge rstN) begin
    if (!rstN) begin
        targetQ104     <= TGT_NONE;
        rdEnQ104       <= 1'b0;
        remoteMatch    <= 1'b0;
        ringDmemRdQ104 <= 1'b0;
        ringCrRdQ104   <= 1'b0;
    end else begin
        targetQ104     <= target;
        rdEnQ104       <= rdEn;
        remoteMatch    <= matchNow;
        ringDmemRdQ104 <= ringDmemRd;
        ringCrRdQ104   <= ringCrRd;
    end
end

// held response data
always_ff @(posedge QClk) begin
    heldQ104 <= heldData;
end

// ====================
// core and ring muxes
// ====================
// held data first, zero when nothing read
assign coreRdData = remoteMatch                               ? heldQ104   :
                    (rdEnQ104 && (targetQ104 == TGT_CR))      ? crRdData   :
                    (rdEnQ104 && (targetQ104 == TGT_DMEM))    ? dmemRdData :
                                                                32'd0;

assign ringRspValid = ringDmemRdQ104 || ringCrRdQ104;
assign ringRspData  = ringDmemRdQ104 ? dmemRingData :
                      ringCrRdQ104   ? crRingData   :
                                       32'd0;

endmodule

// File: logic/dmem_wrap.sv
/* data memory wrapper: routes core and ring accesses to data memory,
   control registers or the ring */
`timescale 1ns/1ps
`include "dmem_settings.svh"

module dmem_wrap
    import dmem_pkg::*;
(
    input  logic        QClk,
    input  logic        rstN,
    input  logic [7:0]  coreId,
    // core side
    input  logic [3:0]  thread,
    input  logic [31:0] addr,
    input  logic [3:0]  byteEn,
    input  logic [31:0] wrData,
    input  logic        rdEn,
    input  logic        wrEn,
    output logic [31:0] coreRdData,
    output logic        remoteMatch,
    // ring inbound
    input  logic        ringReqValid,
    input  tOpcode      ringReqOpcode,
    input  logic [31:0] ringReqAddr,
    input  logic [31:0] ringReqData,
    output logic        ringRspValid,
    output logic [31:0] ringRspData,
    // remote outbound and response
    output logic        remoteReqValid,
    output tOpcode      remoteReqOpcode,
    output logic [1:0]  remoteReqThread,
    output logic [31:0] remoteReqAddr,
    output logic [31:0] remoteReqData,
    input  logic        remoteRspValid,
    input  logic [1:0]  remoteRspThread,
    input  logic [31:0] remoteRspData,
    // status
    output logic [3:0]  threadWaiting,
    output logic [3:0]  threadFrozen
);

logic        dmemRdEn;
logic        dmemWrEn;
logic        crRdEn;
logic        crWrEn;
logic        ringDmemRd;
logic        ringDmemWr;
logic        ringCrRd;
logic        ringCrWr;
tTarget      target;
logic [31:0] heldData;
logic        matchNow;
logic [31:0] dmemRdData;
logic [31:0] dmemRingData;
logic [31:0] crRdData;
logic [31:0] crRingData;

// ====================
// decode
// ====================
access_router i_router (
    .QClk            (QClk),
    .rstN            (rstN),
    .coreId          (coreId),
    .thread          (thread),
    .addr            (addr),
    .rdEn            (rdEn),
    .wrEn            (wrEn),
    .wrData          (wrData),
    .ringReqValid    (ringReqValid),
    .ringReqOpcode   (ringReqOpcode),
    .ringReqAddr     (ringReqAddr),
    .remoteRspValid  (remoteRspValid),
    .remoteRspThread (remoteRspThread),
    .remoteRspData   (remoteRspData),
    .dmemRdEn        (dmemRdEn),
    .dmemWrEn        (dmemWrEn),
    .crRdEn          (crRdEn),
    .crWrEn          (crWrEn),
    .ringDmemRd      (ringDmemRd),
    .ringDmemWr      (ringDmemWr),
    .ringCrRd        (ringCrRd),
    .ringCrWr        (ringCrWr),
    .target          (target),
    .remoteReqValid  (remoteReqValid),
    .remoteReqOpcode (remoteReqOpcode),
    .remoteReqThread (remoteReqThread),
    .remoteReqAddr   (remoteReqAddr),
    .remoteReqData   (remoteReqData),
    .threadWaiting   (threadWaiting),
    .heldData        (heldData),
    .matchNow        (matchNow)
);

// ====================
// storage
// ====================
// word addresses, byte offset dropped
data_sram i_sram (
    .QClk    (QClk),
    .aAddr   (addr[`DMEM_WORD_BITS+1:2]),
    .aByteEn (byteEn),
    .aWrData (wrData),
    .aRdEn   (dmemRdEn),
    .aWrEn   (dmemWrEn),
    .aRdData (dmemRdData),
    .bAddr   (ringReqAddr[`DMEM_WORD_BITS+1:2]),
    .bWrData (ringReqData),
    .bRdEn   (ringDmemRd),
    .bWrEn   (ringDmemWr),
    .bRdData (dmemRingData)
);

ctrl_regs i_cr (
    .QClk         (QClk),
    .rstN         (rstN),
    .coreId       (coreId),
    .thread       (thread),
    .coreAddr     (addr[`DMEM_WORD_BITS+1:2]),
    .coreWrData   (wrData),
    .crRdEn       (crRdEn),
    .crWrEn       (crWrEn),
    .crRdData     (crRdData),
    .ringAddr     (ringReqAddr[`DMEM_WORD_BITS+1:2]),
    .ringWrData   (ringReqData),
    .ringCrRd     (ringCrRd),
    .ringCrWr     (ringCrWr),
    .ringCrData   (crRingData),
    .threadFrozen (threadFrozen)
);

// stage 104 return
read_return i_return (
    .QClk         (QClk),
    .rstN         (rstN),
    .target       (target),
    .rdEn         (rdEn),
    .matchNow     (matchNow),
    .heldData     (heldData),
    .dmemRdData   (dmemRdData),
    .crRdData     (crRdData),
    .ringDmemRd   (ringDmemRd),
    .ringCrRd     (ringCrRd),
    .dmemRingData (dmemRingData),
    .crRingData   (crRingData),
    .coreRdData   (coreRdData),
    .remoteMatch  (remoteMatch),
    .ringRspValid (ringRspValid),
    .ringRspData  (ringRspData)
);

endmodule

// File: testbench/dmem_asserts.sv
/* protocol assertions for the data memory wrapper, bound to dmem_wrap */
`timescale 1ns/1ps
`include "dmem_settings.svh"

module dmem_asserts
    import dmem_pkg::*;
(
    input logic        QClk,
    input logic        rstN,
    input logic        rdEn,
    input logic        wrEn,
    input logic        ringReqValid,
    input tOpcode      ringReqOpcode,
    input logic [31:0] ringReqAddr,
    input logic        ringRspValid,
    input logic        remoteMatch,
    input logic [3:0]  threadWaiting
);

logic [1:0] ringRegion;
logic       ringRead;

// ring read of data memory or control registers, seen at the ring inputs
assign ringRegion = ringReqAddr[`REGION_MSB:`REGION_LSB];
assign ringRead   = ringReqValid && (ringReqOpcode == RD) &&
                    ((ringRegion == `DMEM_REGION) || (ringRegion == `CR_REGION));

// ====================
// core side
// ====================
// one access kind per cycle
assert property (@(posedge QClk) disable iff (!rstN) !(rdEn && wrEn))
    else $error("core rdEn and wrEn high in the same cycle");

// ====================
// ring response
// ====================
assert property (@(posedge QClk) disable iff (!rstN) ringRead |=> ringRspValid)
    else $error("ring read without a response one cycle later");

// no response without a read before it
assert property (@(posedge QClk) disable iff (!rstN)
    ringRspValid |-> $past(ringRead))
    else $error("ring response without a ring read one cycle before");

// waiting bits drop only together with the match
assert property (@(posedge QClk) disable iff (!rstN)
    (|($past(threadWaiting) & ~threadWaiting)) |-> remoteMatch)
    else $error("threadWaiting cleared without remoteMatch");

endmodule

bind dmem_wrap dmem_asserts i_asserts (
    .QClk          (QClk),
    .rstN          (rstN),
    .rdEn          (rdEn),
    .wrEn          (wrEn),
    .ringReqValid  (ringReqValid),
    .ringReqOpcode (ringReqOpcode),
    .ringReqAddr   (ringReqAddr),
    .ringRspValid  (ringRspValid),
    .remoteMatch   (remoteMatch),
    .threadWaiting (threadWaiting)
);

// File: testbench/tb_dmem_wrap.sv
/* testbench for the data memory wrapper, replays records from the stimulus file
   and checks core, ring and remote responses */
`timescale 1ns/1ps

module tb_dmem_wrap
    import dmem_pkg::*;
;

localparam int         WaitLimit   = 16;
localparam logic [7:0] CoreIdValue = 8'h05;

logic        QClk;
logic        rstN;
logic [7:0]  coreId;
logic [3:0]  thread;
logic [31:0] addr;
logic [3:0]  byteEn;
logic [31:0] wrData;
logic        rdEn;
logic        wrEn;
logic [31:0] coreRdData;
logic        remoteMatch;
logic        ringReqValid;
tOpcode      ringReqOpcode;
logic [31:0] ringReqAddr;
logic [31:0] ringReqData;
logic        ringRspValid;
logic [31:0] ringRspData;
logic        remoteReqValid;
tOpcode      remoteReqOpcode;
logic [1:0]  remoteReqThread;
logic [31:0] remoteReqAddr;
logic [31:0] remoteReqData;
logic        remoteRspValid;
logic [1:0]  remoteRspThread;
logic [31:0] remoteRspData;
logic [3:0]  threadWaiting;
logic [3:0]  threadFrozen;

int          fd;
int          fields;
int          records;
string       lineBuf;
string       testName;
string       op;
logic [31:0] fThread;
logic [31:0] fAddr;
logic [31:0] fByteEn;
logic [31:0] fData;
logic [31:0] fExpect;

dmem_wrap i_dut (.*);

// 20 ns clock
initial begin
    QClk = 1'b0;
    forever #10 QClk = ~QClk;
end

task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
endtask

task automatic checkValue(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    assert (actual === expected) else begin
        reportFail($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    end
endtask

// ====================
// drivers, one cycle each
// ====================
task automatic driveCore(input logic [3:0] th, input logic [31:0] ad, input logic [3:0] be,
                         input logic [31:0] dt, input logic rd, input logic wr);
    @(posedge QClk);
    thread         <= th;
    addr           <= ad;
    byteEn         <= be;
    wrData         <= dt;
    rdEn           <= rd;
    wrEn           <= wr;
    ringReqValid   <= 1'b0;
    remoteRspValid <= 1'b0;
endtask

task automatic driveRing(input tOpcode opc, input logic [31:0] ad, input logic [31:0] dt);
    @(posedge QClk);
    rdEn          <= 1'b0;
    wrEn          <= 1'b0;
    ringReqValid  <= 1'b1;
    ringReqOpcode <= opc;
    ringReqAddr   <= ad;
    ringReqData   <= dt;
endtask

task automatic driveIdle();
    @(posedge QClk);
    rdEn           <= 1'b0;
    wrEn           <= 1'b0;
    ringReqValid   <= 1'b0;
    remoteRspValid <= 1'b0;
endtask

// ====================
// bounded waits
// ====================
// request is combinational, expect it in the drive cycle
task automatic waitRemoteReq(output int cycles);
    logic found;
    found  = 1'b0;
    cycles = 0;
    while (!found) begin
        @(negedge QClk);
        found = remoteReqValid;
        if (!found) begin
            cycles++;
            if (cycles >= WaitLimit) begin
                reportFail("timeout: remoteReqValid never went high after a remote access");
            end
        end
    end
endtask

// idles the core while waiting for the match
task automatic waitRemoteMatch(output int cycles);
    logic found;
    found  = 1'b0;
    cycles = 0;
    while (!found) begin
        driveIdle();
        cycles++;
        @(negedge QClk);
        found = remoteMatch;
        if (!found && cycles >= WaitLimit) begin
            reportFail("timeout: remoteMatch never went high after a replay");
        end
    end
endtask

// one record of the stimulus file
task automatic runRecord();
    int cycles;
    if (op == "CW") begin
        driveCore(fThread[3:0], fAddr, fByteEn[3:0], fData, 1'b0, 1'b1);
        driveIdle();
    end else if (op == "CR") begin
        // local data lands one cycle after rdEn
        driveCore(fThread[3:0], fAddr, 4'h0, 32'd0, 1'b1, 1'b0);
        driveIdle();
        @(negedge QClk);
        checkValue({testName, ".coreRdData"}, fExpect, coreRdData);
    end else if (op == "RW") begin
        driveRing(WR, fAddr, fData);
        driveIdle();
    end else if (op == "RR") begin
        driveRing(RD, fAddr, 32'd0);
        driveIdle();
        @(negedge QClk);
        checkValue({testName, ".ringRspValid"}, 32'd1, {31'd0, ringRspValid});
        checkValue({testName, ".ringRspData"}, fExpect, ringRspData);
    end else if (op == "RL" || op == "RS") begin
        driveCore(fThread[3:0], fAddr, fByteEn[3:0], fData, op == "RL", op == "RS");
        waitRemoteReq(cycles);
        checkValue({testName, ".reqCycles"}, 32'd0, cycles);
        checkValue({testName, ".reqOpcode"}, (op == "RL") ? 32'd0 : 32'd1,
                   {30'd0, remoteReqOpcode});
        checkValue({testName, ".reqThread"}, fExpect, {30'd0, remoteReqThread});
        checkValue({testName, ".reqAddr"}, fAddr, remoteReqAddr);
        checkValue({testName, ".reqData"}, fData, remoteReqData);
        driveIdle();
        @(negedge QClk);
        // loads mark the thread as waiting
        if (op == "RL") begin
            checkValue({testName, ".threadWaiting"}, {28'd0, fThread[3:0]},
                       {28'd0, threadWaiting & fThread[3:0]});
        end
    end else if (op == "RP") begin
        @(posedge QClk);
        remoteRspValid  <= 1'b1;
        remoteRspThread <= fThread[1:0];
        remoteRspData   <= fData;
        driveIdle();
    end else if (op == "MT") begin
        driveCore(fThread[3:0], fAddr, 4'h0, 32'd0, 1'b1, 1'b0);
        waitRemoteMatch(cycles);
        checkValue({testName, ".matchCycles"}, 32'd1, cycles);
        checkValue({testName, ".coreRdData"}, fExpect, coreRdData);
        checkValue({testName, ".threadWaiting"}, 32'd0, {28'd0, threadWaiting & fThread[3:0]});
    end else if (op == "NM") begin
        driveCore(fThread[3:0], fAddr, 4'h0, 32'd0, 1'b1, 1'b0);
        driveIdle();
        @(negedge QClk);
        checkValue({testName, ".remoteMatch"}, fExpect, {31'd0, remoteMatch});
    end else if (op == "FZ") begin
        @(negedge QClk);
        checkValue({testName, ".threadFrozen"}, fExpect, {28'd0, threadFrozen});
    end else begin
        reportFail($sformatf("unknown operation %s in record %s", op, testName));
    end
endtask

// ====================
// main sequence
// ====================
initial begin
    rstN            = 1'b0;
    coreId          = CoreIdValue;
    thread          = 4'h0;
    addr            = 32'd0;
    byteEn          = 4'h0;
    wrData          = 32'd0;
    rdEn            = 1'b0;
    wrEn            = 1'b0;
    ringReqValid    = 1'b0;
    ringReqOpcode   = RD;
    ringReqAddr     = 32'd0;
    ringReqData     = 32'd0;
    remoteRspValid  = 1'b0;
    remoteRspThread = 2'd0;
    remoteRspData   = 32'd0;
    records         = 0;
    // reset for 3 cycles
    repeat (3) @(posedge QClk);
    rstN <= 1'b1;

    fd = $fopen("testbench/dmem_stimulus.txt", "r");
    if (fd == 0) begin
        reportFail("could not open the stimulus file");
    end
    while ($fgets(lineBuf, fd) != 0) begin
        testName = "";
        fields = $sscanf(lineBuf, "%s %s %h %h %h %h %h",
                         testName, op, fThread, fAddr, fByteEn, fData, fExpect);
        // blank and comment lines
        if (fields > 0 && testName.len() > 0 && testName[0] != "#") begin
            if (fields != 7) begin
                reportFail($sformatf("malformed stimulus record: %s", lineBuf));
            end
            runRecord();
            records++;
        end
    end
    $fclose(fd);

    if (records > 0) begin
        $display("RESULT: PASS");
        $finish;
    end else begin
        reportFail("the stimulus file held no records");
    end
end

endmodule

// File: filelist.f
+incdir+logic
logic/dmem_pkg.sv
logic/data_sram.sv
logic/ctrl_regs.sv
logic/access_router.sv
logic/read_return.sv
logic/dmem_wrap.sv
testbench/dmem_asserts.sv
testbench/tb_dmem_wrap.sv

// File: testbench/dmem_stimulus.txt
# name op thread addr byteEn data expect, all numbers hex, thread one-hot except RP (binary)
# expect is the read value, the binary thread for RL/RS, the mask for FZ, 0 for NM
dmemFullWr   CW 1 00000010 f 11223344 0
dmemByteWr   CW 1 00000010 5 aabbccdd 0
dmemMerge    CR 1 00000010 0 00000000 11bb33dd
dmemAliasRd  CR 2 05000010 0 00000000 11bb33dd
dmemAliasWr  CW 4 05000014 f cafef00d 0
dmemZeroRd   CR 8 00000014 0 00000000 cafef00d
crScratchWr  CW 1 00c0000c f 5a5a1234 0
crScratchRd  CR 1 00c0000c 0 00000000 5a5a1234
crCoreId     CR 2 00c00020 0 00000000 00000005
crFrozenWr   CW 1 00c00024 f 0000000a 0
crFrozen     FZ 0 00000000 0 00000000 a
crFrozenRd   CR 1 00c00024 0 00000000 0000000a
ringDmemWr   RW 0 00000040 0 13572468 0
ringDmemRd   RR 0 00000040 0 00000000 13572468
ringCoreRd   CR 1 00000040 0 00000000 13572468
ringCrRd     RR 0 00c0000c 0 00000000 5a5a1234
ringCrId     RR 0 00c00020 0 00000000 00000005
remoteLoad   RL 2 07000100 0 00000000 1
remoteStore  RS 4 07000104 f 9abcdef0 2
remoteRsp    RP 1 00000000 0 89abcdef 0
remoteOther  NM 4 07000104 0 00000000 0
remoteMatch  MT 2 07000100 0 00000000 89abcdef
